// File: verilog/exu_pkg.sv
package exu_pkg;

  // data width of the core.
  localparam int xlen = 32;

  typedef logic [xlen-1:0] xlen_t;

  // system operations handed over by the decoder.
  typedef logic [2:0] sys_op_t;

  localparam sys_op_t SYS_NONE  = 3'd0; // not a system instruction.
  localparam sys_op_t SYS_CSRRW = 3'd1; // csrrw and csrrwi.
  localparam sys_op_t SYS_CSRRS = 3'd2; // csrrs and csrrsi.
  localparam sys_op_t SYS_CSRRC = 3'd3; // csrrc and csrrci.
  localparam sys_op_t SYS_ECALL = 3'd4;
  localparam sys_op_t SYS_MRET  = 3'd5;

  // codes 6 and 7 are unused and act like SYS_NONE.

endpackage

// File: verilog/csr_pkg.sv
package csr_pkg;

  import exu_pkg::*;

  typedef logic [11:0] csr_addr_t;

  // machine-mode CSR addresses.
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MVENDORID = 12'hf11;
  localparam csr_addr_t CSR_MARCHID   = 12'hf12;

  // index into the storage array.
  typedef logic [2:0] csr_slot_t;

  localparam csr_slot_t SLOT_NONE    = 3'd0; // sink for unknown or read-only targets.
  localparam csr_slot_t SLOT_MCAUSE  = 3'd1;
  localparam csr_slot_t SLOT_MEPC    = 3'd2;
  localparam csr_slot_t SLOT_MTVEC   = 3'd3;
  localparam csr_slot_t SLOT_MSTATUS = 3'd4;

  // mstatus fields used in machine mode.
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  // identity registers.
  localparam xlen_t MVENDORID_VAL = 32'h7973_7978;
  localparam xlen_t MARCHID_VAL   = 32'h015f_de77;

  // environment call from machine mode.
  localparam xlen_t CAUSE_ECALL_M = 32'd11;

endpackage

// File: verilog/csr_regfile.sv
module csr_regfile
  import exu_pkg::*;
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      exu_valid,
  input  logic      wen,
  input  csr_addr_t csr_addr,
  input  xlen_t     wdata,

  input  logic      trap_en,
  input  xlen_t     trap_epc,
  input  xlen_t     trap_cause,
  input  logic      ret_en,

  output xlen_t     rdata,
  output xlen_t     mepc,
  output xlen_t     mtvec
);

  xlen_t     csr_mem [0:SLOT_MSTATUS]; // slot 0 is never read back.
  csr_slot_t wslot;

  // map the address onto a storage slot.
  always_comb begin
    unique case (csr_addr)
      CSR_MCAUSE:  wslot = SLOT_MCAUSE;
      CSR_MEPC:    wslot = SLOT_MEPC;
      CSR_MTVEC:   wslot = SLOT_MTVEC;
      CSR_MSTATUS: wslot = SLOT_MSTATUS;
      default:     wslot = SLOT_NONE; // identity and unknown addresses.
    endcase
  end

  always_comb begin
    unique case (csr_addr)
      CSR_MVENDORID: rdata = MVENDORID_VAL;
      CSR_MARCHID:   rdata = MARCHID_VAL;
      CSR_MSTATUS:   rdata = csr_mem[SLOT_MSTATUS];
      CSR_MCAUSE:    rdata = csr_mem[SLOT_MCAUSE];
      CSR_MEPC:      rdata = csr_mem[SLOT_MEPC];
      CSR_MTVEC:     rdata = csr_mem[SLOT_MTVEC];
      default:       rdata = '0;
    endcase
  end

  assign mepc  = csr_mem[SLOT_MEPC];
  assign mtvec = csr_mem[SLOT_MTVEC];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i <= SLOT_MSTATUS; i++) begin
        csr_mem[i] <= '0;
      end
    end else if (exu_valid) begin
      if (wen) begin
        csr_mem[wslot] <= wdata;
      end
      // trap entry saves the return point and masks interrupts.
      if (trap_en) begin
        csr_mem[SLOT_MEPC]                 <= trap_epc;
        csr_mem[SLOT_MCAUSE]               <= trap_cause;
        csr_mem[SLOT_MSTATUS][MSTATUS_MPIE] <= csr_mem[SLOT_MSTATUS][MSTATUS_MIE];
        csr_mem[SLOT_MSTATUS][MSTATUS_MIE]  <= 1'b0;
      end
      if (ret_en) begin
        csr_mem[SLOT_MSTATUS][MSTATUS_MIE]  <= csr_mem[SLOT_MSTATUS][MSTATUS_MPIE];
        csr_mem[SLOT_MSTATUS][MSTATUS_MPIE] <= 1'b1; // mret leaves MPIE set.
      end
    end
  end

endmodule

// File: verilog/csr_op_unit.sv
module csr_op_unit
  import exu_pkg::*;
(
  input  sys_op_t sys_op,
  input  xlen_t   src_val,
  input  logic    src_is_x0,
  input  xlen_t   rdata,

  output logic    wen,
  output xlen_t   wdata
);

  // the old value goes to rd on every CSR op, so only the new value is formed here.
  always_comb begin
    unique case (sys_op)
      SYS_CSRRW: begin
        wen   = 1'b1; // csrrw writes even when rs1 is x0.
        wdata = src_val;
      end
      SYS_CSRRS: begin
        wen   = ~src_is_x0; // with x0 as source this is a plain read.
        wdata = rdata | src_val;
      end
      SYS_CSRRC: begin
        wen   = ~src_is_x0;
        wdata = rdata & ~src_val;
      end
      default: begin
        wen   = 1'b0;
        wdata = rdata;
      end
    endcase
  end

endmodule

// File: verilog/trap_ctrl.sv
module trap_ctrl
  import exu_pkg::*;
  import csr_pkg::*;
(
  input  logic    exu_valid,
  input  sys_op_t sys_op,
  input  xlen_t   pc,
  input  xlen_t   mepc,
  input  xlen_t   mtvec,

  output logic    trap_en,
  output xlen_t   trap_epc,
  output xlen_t   trap_cause,
  output logic    ret_en,

  output logic    redirect,
  output xlen_t   redirect_pc
);

  assign trap_en    = (sys_op == SYS_ECALL);
  assign ret_en     = (sys_op == SYS_MRET);
  assign trap_epc   = pc; // ecall returns to itself, the handler adds 4.
  assign trap_cause = CAUSE_ECALL_M;

  // mtvec is direct mode only, so its value is the handler address.
  assign redirect = exu_valid & (trap_en | ret_en);

  always_comb begin
    if (trap_en) begin
      redirect_pc = mtvec;
    end else if (ret_en) begin
      redirect_pc = mepc;
    end else begin
      redirect_pc = '0;
    end
  end

endmodule

// File: verilog/exu_sys.sv
module exu_sys
  import exu_pkg::*;
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  input  logic      exu_valid,
  input  sys_op_t   sys_op,
  input  csr_addr_t csr_addr,
  input  xlen_t     src_val,
  input  logic      src_is_x0,
  input  xlen_t     pc,

  output xlen_t     rd_data,
  output logic      redirect,
  output xlen_t     redirect_pc
);

  xlen_t csr_rdata;
  xlen_t csr_mepc;
  xlen_t csr_mtvec;
  logic  csr_wen;
  xlen_t csr_wdata;
  logic  trap_en;
  xlen_t trap_epc;
  xlen_t trap_cause;
  logic  ret_en;

  assign rd_data = csr_rdata; // old CSR value for writeback.

  csr_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .exu_valid  (exu_valid),
    .wen        (csr_wen),
    .csr_addr   (csr_addr),
    .wdata      (csr_wdata),
    .trap_en    (trap_en),
    .trap_epc   (trap_epc),
    .trap_cause (trap_cause),
    .ret_en     (ret_en),
    .rdata      (csr_rdata),
    .mepc       (csr_mepc),
    .mtvec      (csr_mtvec)
  );

  csr_op_unit u_op (
    .sys_op    (sys_op),
    .src_val   (src_val),
    .src_is_x0 (src_is_x0),
    .rdata     (csr_rdata),
    .wen       (csr_wen),
    .wdata     (csr_wdata)
  );

  trap_ctrl u_trap (
    .exu_valid   (exu_valid),
    .sys_op      (sys_op),
    .pc          (pc),
    .mepc        (csr_mepc),
    .mtvec       (csr_mtvec),
    .trap_en     (trap_en),
    .trap_epc    (trap_epc),
    .trap_cause  (trap_cause),
    .ret_en      (ret_en),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

endmodule

// File: sim/exu_sys_tb.sv
module exu_sys_tb
  import exu_pkg::*;
  import csr_pkg::*;
;

  localparam string TRACE_FILE = "sim/exu_sys_trace.txt";

  // one cycle of stimulus and the outputs expected in that cycle.
  typedef struct packed {
    logic [31:0] test_num;
    logic        valid;
    sys_op_t     op;
    csr_addr_t   addr;
    xlen_t       src;
    logic        src_x0;
    xlen_t       pc;
    xlen_t       exp_rd;
    logic        exp_redirect;
    xlen_t       exp_redirect_pc;
  } trace_line_t;

  logic      clk = 1'b0;
  logic      rst;
  logic      exu_valid;
  sys_op_t   sys_op;
  csr_addr_t csr_addr;
  xlen_t     src_val;
  logic      src_is_x0;
  xlen_t     pc;
  xlen_t     rd_data;
  logic      redirect;
  xlen_t     redirect_pc;

  trace_line_t trace_q [$];
  logic [31:0] cur_test;
  int          error_count = 0;
  int          test_errors = 0;
  int          test_count = 0;
  int          watchdog_delay = 0;
  logic        trace_loaded = 1'b0;

  exu_sys exu_sys_i (
    .clk         (clk),
    .rst         (rst),
    .exu_valid   (exu_valid),
    .sys_op      (sys_op),
    .csr_addr    (csr_addr),
    .src_val     (src_val),
    .src_is_x0   (src_is_x0),
    .pc          (pc),
    .rd_data     (rd_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s in test %0d: got %h, expected %h", name, cur_test, actual, expected);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic report_test(input logic [31:0] num);
    $display("test %0d finished with %0d errors", num, test_errors);
    test_count++;
    test_errors = 0;
  endtask

  task automatic load_trace();
    int          fd;
    int          count;
    string       line;
    logic [31:0] f [0:9];
    trace_line_t entry;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("the trace file %s could not be opened", TRACE_FILE);
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) == 0) break;
        if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") continue;
        count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                        f[4], f[5], f[6], f[7], f[8], f[9]);
        if (count != 10) begin
          $display("a trace line has %0d fields instead of 10: %s", count, line);
          error_count++;
          continue;
        end
        entry.test_num        = f[0];
        entry.valid           = f[1][0];
        entry.op              = f[2][2:0];
        entry.addr            = f[3][11:0];
        entry.src             = f[4];
        entry.src_x0          = f[5][0];
        entry.pc              = f[6];
        entry.exp_rd          = f[7];
        entry.exp_redirect    = f[8][0];
        entry.exp_redirect_pc = f[9];
        trace_q.push_back(entry);
      end
      $fclose(fd);
    end
  endtask

  // the run length follows from the number of trace cycles.
  initial begin
    wait (trace_loaded);
    #(watchdog_delay);
    $display("timeout, the run did not finish within %0d time units", watchdog_delay);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int          idx;
    trace_line_t entry;
    rst       <= 1'b1;
    exu_valid <= 1'b0;
    sys_op    <= SYS_NONE;
    csr_addr  <= '0;
    src_val   <= '0;
    src_is_x0 <= 1'b0;
    pc        <= '0;
    cur_test  = '0;
    load_trace();
    watchdog_delay = trace_q.size() * 10 + 200;
    trace_loaded = 1'b1;

    repeat (10) @(posedge clk);
    rst <= 1'b0;

    if (trace_q.size() == 0) begin
      $display("no stimulus was applied because the trace holds no usable lines");
      error_count++;
    end else begin
      cur_test = trace_q[0].test_num;
      for (idx = 0; idx < trace_q.size(); idx++) begin
        entry = trace_q[idx];
        if (entry.test_num != cur_test) begin
          report_test(cur_test);
          cur_test = entry.test_num;
        end
        @(posedge clk);
        exu_valid <= entry.valid;
        sys_op    <= entry.op;
        csr_addr  <= entry.addr;
        src_val   <= entry.src;
        src_is_x0 <= entry.src_x0;
        pc        <= entry.pc;
        @(negedge clk); // outputs are settled half a cycle after the drive.
        check_value("rd_data", rd_data, entry.exp_rd);
        check_value("redirect", {31'd0, redirect}, {31'd0, entry.exp_redirect});
        if (entry.exp_redirect) begin
          check_value("redirect_pc", redirect_pc, entry.exp_redirect_pc);
        end
      end
      report_test(cur_test);
    end

    $display("%0d tests run, %0d errors", test_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: sim/exu_sys_trace.txt
# test valid sys_op csr_addr src_val src_is_x0 pc exp_rd_data exp_redirect exp_redirect_pc
# all fields hex; exp_redirect_pc is compared only on lines that expect a redirect.
1 1 2 300 00000000 1 00000000 00000000 0 00000000
1 1 2 305 00000000 1 00000000 00000000 0 00000000
1 1 2 341 00000000 1 00000000 00000000 0 00000000
1 1 2 342 00000000 1 00000000 00000000 0 00000000
1 1 2 f11 00000000 1 00000000 79737978 0 00000000
1 1 2 f12 00000000 1 00000000 015fde77 0 00000000
1 1 2 7c0 00000000 1 00000000 00000000 0 00000000
1 0 0 000 00000000 0 00000000 00000000 0 00000000
2 1 1 305 00000100 0 00000000 00000000 0 00000000
2 1 1 305 00000200 0 00000000 00000100 0 00000000
2 1 2 305 00000000 1 00000000 00000200 0 00000000
2 1 1 341 00001000 0 00000000 00000000 0 00000000
2 1 2 341 00000000 1 00000000 00001000 0 00000000
2 1 1 342 00000005 0 00000000 00000000 0 00000000
2 1 2 342 00000000 1 00000000 00000005 0 00000000
2 1 1 300 00000088 0 00000000 00000000 0 00000000
2 1 2 300 00000000 1 00000000 00000088 0 00000000
2 1 1 f11 deadbeef 0 00000000 79737978 0 00000000
2 1 2 f11 00000000 1 00000000 79737978 0 00000000
2 1 1 7c0 12345678 0 00000000 00000000 0 00000000
2 1 2 7c0 00000000 1 00000000 00000000 0 00000000
2 1 2 300 00000000 1 00000000 00000088 0 00000000
2 1 2 305 00000000 1 00000000 00000200 0 00000000
2 1 2 341 00000000 1 00000000 00001000 0 00000000
2 1 2 342 00000000 1 00000000 00000005 0 00000000
2 1 2 f12 00000000 1 00000000 015fde77 0 00000000
3 1 2 342 000000f0 0 00000000 00000005 0 00000000
3 1 2 342 00000000 1 00000000 000000f5 0 00000000
3 1 3 342 00000011 0 00000000 000000f5 0 00000000
3 1 2 342 00000000 1 00000000 000000e4 0 00000000
3 1 2 342 ffff0000 1 00000000 000000e4 0 00000000
3 1 3 342 000000e4 1 00000000 000000e4 0 00000000
3 1 2 342 00000000 1 00000000 000000e4 0 00000000
4 1 3 300 00000080 0 00000000 00000088 0 00000000
4 1 4 000 00000000 0 00000400 00000000 1 00000200
4 1 2 341 00000000 1 00000000 00000400 0 00000000
4 1 2 342 00000000 1 00000000 0000000b 0 00000000
4 1 2 300 00000000 1 00000000 00000080 0 00000000
5 1 5 000 00000000 0 00000000 00000000 1 00000400
5 1 2 300 00000000 1 00000000 00000088 0 00000000
5 1 3 300 00000088 0 00000000 00000088 0 00000000
5 1 4 000 00000000 0 00000500 00000000 1 00000200
5 1 5 000 00000000 0 00000000 00000000 1 00000500
5 1 2 300 00000000 1 00000000 00000080 0 00000000
5 1 1 341 00000abc 0 00000000 00000500 0 00000000
5 1 5 000 00000000 0 00000000 00000000 1 00000abc
5 1 2 300 00000000 1 00000000 00000088 0 00000000
6 0 1 305 11111111 0 00000000 00000200 0 00000000
6 0 4 300 00000000 0 00000700 00000088 0 00000000
6 0 5 341 00000000 0 00000000 00000abc 0 00000000
6 0 2 342 ffffffff 0 00000000 0000000b 0 00000000
6 0 3 300 ffffffff 0 00000000 00000088 0 00000000
6 1 2 305 00000000 1 00000000 00000200 0 00000000
6 1 2 300 00000000 1 00000000 00000088 0 00000000
6 1 2 341 00000000 1 00000000 00000abc 0 00000000
6 1 2 342 00000000 1 00000000 0000000b 0 00000000
6 1 1 305 00000300 0 00000000 00000200 0 00000000
6 1 2 305 0000000c 0 00000000 00000300 0 00000000
6 1 3 305 00000300 0 00000000 0000030c 0 00000000
6 1 4 000 00000000 0 00000800 00000000 1 0000000c
6 1 5 000 00000000 0 00000000 00000000 1 00000800
6 1 2 341 00000000 1 00000000 00000800 0 00000000
6 0 0 000 00000000 0 00000000 00000000 0 00000000

// File: filelist.f
verilog/exu_pkg.sv
verilog/csr_pkg.sv
verilog/csr_regfile.sv
verilog/csr_op_unit.sv
verilog/trap_ctrl.sv
verilog/exu_sys.sv
sim/exu_sys_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module exu_sys_tb -f filelist.f -o exu_sys_sim

sim_output=$(./obj_dir/exu_sys_sim)
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -qx "NO ERRORS"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
